/* hdl/mdll_pkg.sv */
// mdll supply dac package: shared widths, voltage codes and vector types
`default_nettype none

package mdll_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    localparam int N_DAC_TI   = 5;              // binary tap index width
    localparam int N_DAC_TAPS = 2**N_DAC_TI;    // 32 ladder taps
    localparam int N_DAC_GAIN = 4;              // gain switches
    localparam int N_DAC_BW   = 3;              // decap enable bits
    localparam int N_VOUT     = 16;             // voltage word, 0.5 mV per lsb

    // ----------------------------------------------------------
    // voltage codes, all in 0.5 mV units
    // ----------------------------------------------------------
    localparam int VOFFSET_CODE  = 1600;        // 800 mV ladder offset
    localparam int LSB0_CODE     = 8;           // base step per tap
    localparam int VSF_DROP_CODE = 400;         // source-follower vgs drop

    // gain request above this saturates
    localparam int GAIN_SAT  = 4;
    localparam int KGAIN_MAX = GAIN_SAT + 1;    // largest step multiplier

    // target at code 0, also the filter reset value
    localparam int VRESET_CODE = VOFFSET_CODE - VSF_DROP_CODE;

    // target at top code with max gain
    localparam int VOUT_MAX_CODE =
        VOFFSET_CODE + LSB0_CODE * KGAIN_MAX * (N_DAC_TAPS - 1) - VSF_DROP_CODE;

    // iir shift with no decap enabled, widest bandwidth step
    localparam int IIR_SHIFT_MAX = N_DAC_BW + 1;

    // ----------------------------------------------------------
    // vector types
    // ----------------------------------------------------------
    typedef logic [N_DAC_TI-1:0]   dac_code_t;  // binary tap index
    typedef logic [N_DAC_TAPS-1:0] dac_sel_t;   // one-cold tap select
    typedef logic [2:0]            gain_sel_t;  // requested gain 0..7
    typedef logic [N_DAC_GAIN-1:0] gain_oc_t;   // one-cold gain switches
    typedef logic [1:0]            bw_sel_t;    // requested bandwidth 0..3
    typedef logic [N_DAC_BW-1:0]   bw_thm_t;    // thermometer, low bits first
    typedef logic [N_VOUT-1:0]     vout_t;      // unsigned voltage word

    // step multiplier 1..KGAIN_MAX
    typedef logic [$clog2(KGAIN_MAX+1)-1:0] kgain_t;

    // iir right shift 1..IIR_SHIFT_MAX
    typedef logic [$clog2(IIR_SHIFT_MAX+1)-1:0] shift_t;

endpackage

`default_nettype wire

/* hdl/mdll_dac_ctrl_decoder.sv */
// dac control decoder: latches the settings on upd, drives one-cold and thermometer controls
`default_nettype none

module mdll_dac_ctrl_decoder (
    input  wire                   iir_clk,
    input  wire                   rst,
    input  wire                   upd,               // single-cycle update strobe
    input  mdll_pkg::dac_code_t   dac_code,
    input  mdll_pkg::gain_sel_t   gain_sel,
    input  mdll_pkg::bw_sel_t     bw_sel,
    output mdll_pkg::dac_sel_t    dinb_sel,          // one-cold tap select
    output mdll_pkg::gain_oc_t    ctlb_dac_gain_oc,  // one-cold gain, all ones = base
    output mdll_pkg::bw_thm_t     ctl_dac_bw_thm     // decap enables, thermometer
);

    import mdll_pkg::*;

    // ----------------------------------------------------------
    // encoders
    // ----------------------------------------------------------

    // tap k selected by pulling bit k low
    function automatic dac_sel_t enc_tap(input dac_code_t code);
        return ~(dac_sel_t'(1) << code);
    endfunction

    // 0 -> base gain, 1..4 -> clear bit g-1, above 4 clamps
    function automatic gain_oc_t enc_gain(input gain_sel_t g);
        gain_sel_t sat;
        sat = (g > gain_sel_t'(GAIN_SAT)) ? gain_sel_t'(GAIN_SAT) : g;
        if (sat == '0) begin
            return '1;                      // no switch closed
        end
        return ~(gain_oc_t'(1) << (sat - 3'd1));
    endfunction

    // b ones from the bottom
    function automatic bw_thm_t enc_bw(input bw_sel_t b);
        logic [N_DAC_BW:0] ext;             // one spare bit for 2**b
        ext = ({{N_DAC_BW{1'b0}}, 1'b1} << b) - 1'b1;
        return ext[N_DAC_BW-1:0];
    endfunction

    // ----------------------------------------------------------
    // control registers
    // ----------------------------------------------------------

    // encoded forms held between strobes, one cycle after upd
    always_ff @(posedge iir_clk) begin
        if (rst) begin
            dinb_sel         <= enc_tap('0);   // tap 0
            ctlb_dac_gain_oc <= '1;            // Kgain 1
            ctl_dac_bw_thm   <= '0;            // no decap, widest step
        end else if (upd) begin
            dinb_sel         <= enc_tap(dac_code);
            ctlb_dac_gain_oc <= enc_gain(gain_sel);
            ctl_dac_bw_thm   <= enc_bw(bw_sel);
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // the ladder decoder must see exactly one closed switch
    a_tap_one_cold: assert property (
        @(posedge iir_clk) disable iff (rst)
        $onehot(~dinb_sel)
    ) else $error("dinb_sel %h not one-cold", dinb_sel);

    // thermometer shape, no enable above a disabled bit
    a_bw_thermo: assert property (
        @(posedge iir_clk) disable iff (rst)
        ((ctl_dac_bw_thm + 1'b1) & ctl_dac_bw_thm) == '0
    ) else $error("ctl_dac_bw_thm %b not thermometer", ctl_dac_bw_thm);

endmodule

`default_nettype wire

/* hdl/mdll_supply_dac_filter.sv */
// supply dac filter: first-order iir low-pass, shift picked by the decap thermometer
`default_nettype none

module mdll_supply_dac_filter (
    input  wire                  iir_clk,
    input  wire                  rst,
    input  mdll_pkg::bw_thm_t    ctl_dac_bw_thm,   // more ones, more decap
    input  mdll_pkg::vout_t      vin,              // unfiltered target
    output mdll_pkg::vout_t      vout
);

    import mdll_pkg::*;

    // ----------------------------------------------------------
    // bandwidth select
    // ----------------------------------------------------------

    // popcount of the enables
    function automatic shift_t thm_count(input bw_thm_t thm);
        shift_t n;
        n = '0;
        for (int i = 0; i < N_DAC_BW; i++) begin
            n = n + shift_t'(thm[i]);
        end
        return n;
    endfunction

    shift_t shift;         // 4 with no decap, down to 1
    assign shift = shift_t'(IIR_SHIFT_MAX) - thm_count(ctl_dac_bw_thm);

    // ----------------------------------------------------------
    // iir state
    // ----------------------------------------------------------

    vout_t                   y;        // node voltage
    logic signed [N_VOUT:0]  diff;     // vin - y, one sign bit
    logic signed [N_VOUT:0]  step;     // diff >>> shift, floor rounding
    logic signed [N_VOUT:0]  y_sum;
    vout_t                   y_nxt;

    always_comb begin
        diff  = $signed({1'b0, vin}) - $signed({1'b0, y});
        step  = diff >>> shift;                // arithmetic, toward -inf
        y_sum = $signed({1'b0, y}) + step;
        y_nxt = y_sum[N_VOUT-1:0];             // never leaves [y, vin]
    end

    // settles at the code 0 target
    always_ff @(posedge iir_clk) begin
        if (rst) begin
            y <= vout_t'(VRESET_CODE);
        end else begin
            y <= y_nxt;
        end
    end

    assign vout = y;

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // no overshoot past the largest target the dac can ask for
    a_vout_max: assert property (
        @(posedge iir_clk) disable iff (rst)
        int'(vout) <= VOUT_MAX_CODE
    ) else $error("vout %0d above max target", vout);

endmodule

`default_nettype wire

/* hdl/mdll_dcdl_supply_dac.sv */
// dcdl supply dac: decodes tap and gain controls into a fixed-point target and filters it
`default_nettype none

module mdll_dcdl_supply_dac (
    input  wire                  iir_clk,
    input  wire                  rst,
    input  mdll_pkg::bw_thm_t    ctl_dac_bw_thm,     // decap enables
    input  mdll_pkg::gain_oc_t   ctlb_dac_gain_oc,   // one-cold gain switches
    input  mdll_pkg::dac_sel_t   dinb_sel,           // one-cold tap select
    output mdll_pkg::vout_t      vout                // filtered dcdl supply
);

    import mdll_pkg::*;

    // ----------------------------------------------------------
    // control decode
    // ----------------------------------------------------------

    dac_code_t din;        // recovered tap index
    gain_oc_t  gain_oh;    // active-high gain switches
    kgain_t    kgain;      // step multiplier 1..5
    vout_t     vtarget;    // follower output before decap

    assign gain_oh = ~ctlb_dac_gain_oc;

    // lowest low bit wins, like the first closed pass switch
    always_comb begin
        logic found;
        found = 1'b0;
        din   = '0;
        for (int m = 0; m < N_DAC_TAPS; m++) begin
            if (!found && !dinb_sel[m]) begin
                din   = dac_code_t'(m);
                found = 1'b1;
            end
        end
    end

    // each gain switch shorts part of the ladder, raising the step
    always_comb begin
        case (gain_oh)
            4'b0000: kgain = kgain_t'(1);    // all open, base step
            4'b0001: kgain = kgain_t'(2);
            4'b0010: kgain = kgain_t'(3);
            4'b0100: kgain = kgain_t'(4);
            4'b1000: kgain = kgain_t'(5);
            default: kgain = kgain_t'(1);    // illegal, fall back to base
        endcase
    end

    // ----------------------------------------------------------
    // target voltage
    // ----------------------------------------------------------

    // offset + step*code, less the follower drop, floored at 0 V
    always_comb begin
        int vsum;
        vsum = VOFFSET_CODE
             + LSB0_CODE * int'(kgain) * int'(din)
             - VSF_DROP_CODE;
        if (vsum < 0) begin
            vtarget = '0;                    // follower cut off
        end else begin
            vtarget = vout_t'(vsum);
        end
    end

    // ----------------------------------------------------------
    // decap network
    // ----------------------------------------------------------

    mdll_supply_dac_filter u_lpf (
        .iir_clk        (iir_clk),
        .rst            (rst),
        .ctl_dac_bw_thm (ctl_dac_bw_thm),
        .vin            (vtarget),
        .vout           (vout)
    );

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------

    // decoder must never close two gain switches at once
    a_gain_one_cold: assert property (
        @(posedge iir_clk) disable iff (rst)
        $onehot0(gain_oh)
    ) else $error("ctlb_dac_gain_oc %b not one-cold", ctlb_dac_gain_oc);

endmodule

`default_nettype wire

/* hdl/mdll_supply_dac_top.sv */
// mdll supply dac top: control decoder feeding the dcdl supply dac
`default_nettype none

module mdll_supply_dac_top (
    input  wire                   iir_clk,
    input  wire                   rst,
    input  wire                   upd,          // settings strobe
    input  mdll_pkg::dac_code_t   dac_code,
    input  mdll_pkg::gain_sel_t   gain_sel,
    input  mdll_pkg::bw_sel_t     bw_sel,
    output mdll_pkg::vout_t       vout          // dcdl supply, 0.5 mV lsb
);

    import mdll_pkg::*;

    // ----------------------------------------------------------
    // decoder to dac controls
    // ----------------------------------------------------------

    dac_sel_t dinb_sel;            // one-cold tap
    gain_oc_t ctlb_dac_gain_oc;    // one-cold gain
    bw_thm_t  ctl_dac_bw_thm;      // decap thermometer

    mdll_dac_ctrl_decoder u_ctrl (
        .iir_clk          (iir_clk),
        .rst              (rst),
        .upd              (upd),
        .dac_code         (dac_code),
        .gain_sel         (gain_sel),
        .bw_sel           (bw_sel),
        .dinb_sel         (dinb_sel),
        .ctlb_dac_gain_oc (ctlb_dac_gain_oc),
        .ctl_dac_bw_thm   (ctl_dac_bw_thm)
    );

    // target and decap filter
    mdll_dcdl_supply_dac u_dac (
        .iir_clk          (iir_clk),
        .rst              (rst),
        .ctl_dac_bw_thm   (ctl_dac_bw_thm),
        .ctlb_dac_gain_oc (ctlb_dac_gain_oc),
        .dinb_sel         (dinb_sel),
        .vout             (vout)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// testbench clock and reset: free-running clock, reset held high for the first few cycles
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,     // clock period
    parameter int RST_CYCLES = 4       // rising edges with rst high
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after an edge, ahead of the stimulus drive point
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* dv/mdll_supply_dac_tb.sv */
// supply dac testbench: random and directed settings checked cycle by cycle against a model
`default_nettype none

module mdll_supply_dac_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mdll_pkg::*;

    // ----------------------------------------------------------
    // run length and watchdog
    // ----------------------------------------------------------
    localparam int CLK_PERIOD_NS = 20;
    localparam int RST_CYCLES    = 4;
    localparam int HOLD_CYCLES   = 20;      // idle after reset, upd low
    localparam int RAND_CYCLES   = 2000;
    localparam int SETTLE_MAX    = 200;     // cap per settle phase
    localparam int N_SETTLES     = 20;      // directed settles, rounded up
    localparam int EXTRA_CYCLES  = 40;      // strobe cycles of directed tests
    localparam int GAIN_CLAMP    = 4;       // gain request saturates here
    localparam int WATCHDOG_NS   =
        (RST_CYCLES + HOLD_CYCLES + RAND_CYCLES + N_SETTLES * SETTLE_MAX
         + EXTRA_CYCLES) * CLK_PERIOD_NS + 1000;

    logic      iir_clk;
    logic      rst;
    logic      upd;
    dac_code_t dac_code;
    gain_sel_t gain_sel;
    bw_sel_t   bw_sel;
    vout_t     vout;

    // model state
    int          m_y;          // filter node
    int          m_code;       // registered tap index
    int          m_gain;       // registered Kgain 1..5
    int          m_shift;      // registered iir shift 4..1
    bit          m_moved;      // last edge changed m_y
    int          errors;
    int          checks;
    logic [31:0] rng;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(RST_CYCLES)) u_clk (
        .clk (iir_clk),
        .rst (rst)
    );

    mdll_supply_dac_top u_dut (
        .iir_clk  (iir_clk),
        .rst      (rst),
        .upd      (upd),
        .dac_code (dac_code),
        .gain_sel (gain_sel),
        .bw_sel   (bw_sel),
        .vout     (vout)
    );

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // request 0 is base gain, each step above adds one, clamp at 4
    function automatic int kgain_of(input int g);
        int sat;
        sat = (g > GAIN_CLAMP) ? GAIN_CLAMP : g;
        return sat + 1;
    endfunction

    // offset plus gain step times code, less the follower drop
    function automatic int target_of(input int code, input int kg);
        int v;
        v = VOFFSET_CODE + LSB0_CODE * kg * code - VSF_DROP_CODE;
        return (v < 0) ? 0 : v;
    endfunction

    // one rising edge: filter on old controls, then capture on upd
    task automatic model_edge();
        int tgt;
        int step;
        if (rst) begin
            m_y     = VOFFSET_CODE - VSF_DROP_CODE;
            m_code  = 0;
            m_gain  = 1;
            m_shift = 4;
            m_moved = 1'b0;
        end else begin
            tgt     = target_of(m_code, m_gain);
            step    = (tgt - m_y) >>> m_shift;   // floor toward -inf
            m_y     = m_y + step;
            m_moved = (step != 0);
            if (upd) begin
                m_code  = int'(dac_code);
                m_gain  = kgain_of(int'(gain_sel));
                m_shift = 4 - int'(bw_sel);
            end
        end
    endtask

    // ----------------------------------------------------------
    // cycle and check helpers
    // ----------------------------------------------------------
    task automatic compare_vout();
        checks++;
        assert (vout === vout_t'(m_y)) else begin
            errors++;
            $display("Error: %0t ns vout %0d expected %0d", $time, vout, m_y);
        end
    endtask

    // returns 2 ns after the edge, the drive point
    task automatic run_cycle();
        @(posedge iir_clk);
        model_edge();
        #1;
        compare_vout();
        #1;
    endtask

    task automatic apply_update(input int code, input int gain, input int bw);
        upd      = 1'b1;
        dac_code = dac_code_t'(code);
        gain_sel = gain_sel_t'(gain);
        bw_sel   = bw_sel_t'(bw);
        run_cycle();                         // capture edge
        upd      = 1'b0;
    endtask

    // step until the model node stops moving
    task automatic settle();
        int n;
        n = 0;
        do begin
            run_cycle();
            n++;
        end while (m_moved && n < SETTLE_MAX);
        if (m_moved) begin
            errors++;
            $display("Output was still moving after %0d cycles of settling", n);
        end
    endtask

    // from below the floor step stalls short of the target by under 2**shift
    task automatic check_settled(input int tgt, input int shift);
        int v;
        v = int'(vout);
        checks++;
        assert (v <= tgt && tgt - v < (1 << shift)) else begin
            errors++;
            $display("Error: %0t ns settled vout %0d too far from target %0d",
                     $time, v, tgt);
        end
    endtask

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    initial begin
        int prev;
        upd      = 1'b0;
        dac_code = '0;
        gain_sel = '0;
        bw_sel   = '0;
        errors   = 0;
        checks   = 0;
        rng      = 32'd6973;

        while (rst) run_cycle();

        // reset value holds while upd stays low
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            rng      = lcg_next(rng);
            dac_code = rng[29:25];
            gain_sel = rng[24:22];
            bw_sel   = rng[21:20];
            run_cycle();
            checks++;
            assert (vout === vout_t'(VOFFSET_CODE - VSF_DROP_CODE)) else begin
                errors++;
                $display("Error: %0t ns vout %0d moved without upd", $time, vout);
            end
        end

        // random strobes, about one cycle in four
        for (int i = 0; i < RAND_CYCLES; i++) begin
            rng      = lcg_next(rng);
            upd      = (rng[31:30] == 2'b00);
            dac_code = rng[29:25];
            gain_sel = rng[24:22];
            bw_sel   = rng[21:20];
            run_cycle();
        end
        upd = 1'b0;

        // every gain request at the top code, widest step
        for (int g = 0; g < 8; g++) begin
            apply_update(31, g, 0);
            settle();
            check_settled(target_of(31, kgain_of(g)), 4);
        end

        // same upward step under each decap setting
        for (int b = 0; b < 4; b++) begin
            apply_update(0, 2, b);
            settle();
            apply_update(24, 2, b);
            settle();
            check_settled(target_of(24, kgain_of(2)), 4 - b);
        end

        // high to low, floor rounding lands exactly
        apply_update(31, 4, 1);
        settle();
        prev = int'(vout);
        apply_update(0, 4, 1);
        checks++;
        assert (int'(vout) == prev) else begin
            errors++;
            $display("Error: %0t ns vout %0d changed on the capture edge", $time, vout);
        end
        run_cycle();
        checks++;
        assert (int'(vout) < prev) else begin
            errors++;
            $display("Error: %0t ns vout %0d not falling 2 cycles after upd",
                     $time, vout);
        end
        settle();
        checks++;
        assert (int'(vout) == target_of(0, kgain_of(4))) else begin
            errors++;
            $display("Error: %0t ns vout %0d did not reach floor target", $time, vout);
        end

        // strobes on consecutive cycles, last one wins
        apply_update(5, 1, 3);
        apply_update(17, 6, 0);
        apply_update(9, 3, 2);
        apply_update(28, 2, 1);
        settle();
        check_settled(target_of(28, kgain_of(2)), 3);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* mdll_supply_dac_top.f */
hdl/mdll_pkg.sv
hdl/mdll_dac_ctrl_decoder.sv
hdl/mdll_supply_dac_filter.sv
hdl/mdll_dcdl_supply_dac.sv
hdl/mdll_supply_dac_top.sv
dv/tb_clk_gen.sv
dv/mdll_supply_dac_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the supply dac testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=mdll_supply_dac_tb
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module "$TOP" -Mdir "$BUILD" -f mdll_supply_dac_top.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$("./$BUILD/V$TOP" 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "pass message not found"
exit 1
